//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
RTL_TOP   ?= line_swap_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= src/cam_pkg.sv src/line_buffer.sv src/capture_sequencer.sv \
             src/readout_mux.sv src/line_swap_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST OK"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
src/cam_pkg.sv
src/line_buffer.sv
src/capture_sequencer.sv
src/readout_mux.sv
src/line_swap_top.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- src/cam_pkg.sv
package cam_pkg;

    ////////////////////////////////////////////////////////////
    // line geometry and widths
    ////////////////////////////////////////////////////////////
    localparam int H_ACT   = 32;                   // pixels per line.
    localparam int NUM_CAM = 2;
    localparam int ROW_W   = 11;
    localparam int COL_W   = 11;
    localparam int PIX_W   = 16;
    localparam int FRM_W   = 16;                   // frame count in the header view.
    localparam int RSVD_W  = 20;
    localparam int PACK_W  = 49;
    localparam int ID_W    = 5;
    localparam int ADDR_W  = $clog2(H_ACT);        // read pointer width.
    localparam int CNT_W   = $clog2(H_ACT + 1);    // write count runs up to H_ACT.

    // one-hot camera ids, index 0 sits in the low word.
    localparam logic [NUM_CAM-1:0][ID_W-1:0] CAM_ID = {5'b01000, 5'b10000};

    // line buffer states.
    localparam logic [1:0] LB_IDLE  = 2'd0;
    localparam logic [1:0] LB_HDR   = 2'd1;
    localparam logic [1:0] LB_FILL  = 2'd2;
    localparam logic [1:0] LB_DRAIN = 2'd3;

    // capture sequencer states.
    localparam logic [1:0] SQ_IDLE = 2'd0;
    localparam logic [1:0] SQ_TRIG = 2'd1;
    localparam logic [1:0] SQ_WAIT = 2'd2;
    localparam logic [1:0] SQ_GAP  = 2'd3;

    typedef struct packed {
        logic              valid;
        logic              is_header;
        logic [ROW_W-1:0]  row;
        logic [FRM_W-1:0]  frame;
        logic [RSVD_W-1:0] rsvd;
    } cam_hdr_t;

    typedef struct packed {
        logic              valid;
        logic              is_header;
        logic [COL_W-1:0]  col;
        logic [PIX_W-1:0]  data;
        logic [RSVD_W-1:0] rsvd;
    } cam_pix_t;

    // the same 49-bit word seen as a header or as a pixel.
    typedef union packed {
        cam_hdr_t hdr;
        cam_pix_t pix;
    } cam_pack_t;

endpackage : cam_pkg

//--- src/capture_sequencer.sv
module capture_sequencer (
    input  logic                        rclk,
    input  logic                        rstn,
    input  logic                        trig,
    input  logic [cam_pkg::NUM_CAM-1:0] busy,
    output logic [cam_pkg::NUM_CAM-1:0] cap_trig,
    output logic                        cam_sel
);

    logic [1:0] state;
    logic       pending;
    logic       last_cam;

    assign last_cam = (cam_sel == 1'(cam_pkg::NUM_CAM - 1));

    // a trigger during a round folds into one more round.
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            pending <= 1'b0;
        end else if (trig) begin
            pending <= 1'b1;
        end else if (state == cam_pkg::SQ_IDLE) begin
            pending <= 1'b0;                          // consumed as the round starts.
        end
    end

    ////////////////////////////////////////////////////////////
    // round FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state    <= cam_pkg::SQ_IDLE;
            cap_trig <= '0;
            cam_sel  <= 1'b0;
        end else begin
            case (state)
                cam_pkg::SQ_IDLE: begin
                    cap_trig <= '0;
                    cam_sel  <= 1'b0;
                    if (pending) begin
                        state <= cam_pkg::SQ_TRIG;
                    end
                end
                cam_pkg::SQ_TRIG: begin
                    // hold the level until the buffer reports busy.
                    if (busy[cam_sel]) begin
                        cap_trig[cam_sel] <= 1'b0;
                        state             <= cam_pkg::SQ_WAIT;
                    end else begin
                        cap_trig[cam_sel] <= 1'b1;
                    end
                end
                cam_pkg::SQ_WAIT: begin
                    if (!busy[cam_sel]) begin
                        state <= last_cam ? cam_pkg::SQ_IDLE : cam_pkg::SQ_GAP;
                    end
                end
                cam_pkg::SQ_GAP: begin
                    if (busy == '0) begin
                        cam_sel <= cam_sel + 1'b1;
                        state   <= cam_pkg::SQ_TRIG;
                    end
                end
                default: begin
                    state <= cam_pkg::SQ_IDLE;
                end
            endcase
        end
    end

    a_one_trig: assert property (@(posedge rclk) disable iff (!rstn)
        $onehot0(cap_trig));

endmodule : capture_sequencer

//--- src/line_buffer.sv
module line_buffer (
    input  logic                      rclk,
    input  logic                      rstn,
    input  cam_pkg::cam_pack_t        cam_pack,
    input  logic                      cap_trig,
    output logic                      line_ready,
    output logic                      busy,
    input  logic                      rd_en,
    output logic [cam_pkg::PIX_W-1:0] pix_data,
    output logic [cam_pkg::ROW_W-1:0] row,
    output logic                      line_err
);

    logic [1:0]                       state;
    logic [cam_pkg::PIX_W-1:0]        mem [cam_pkg::H_ACT];
    logic [cam_pkg::CNT_W-1:0]        wr_cnt;
    logic [cam_pkg::ADDR_W-1:0]       rd_ptr;
    logic                             hdr_hit;
    logic                             pix_hit;
    logic                             col_bad;
    logic                             last_wr;
    logic                             last_rd;

    assign hdr_hit = cam_pack.hdr.valid && cam_pack.hdr.is_header && (state == cam_pkg::LB_HDR);
    assign pix_hit = cam_pack.pix.valid && !cam_pack.pix.is_header
                     && (state == cam_pkg::LB_FILL);
    assign col_bad = pix_hit && (cam_pack.pix.col != cam_pkg::COL_W'(wr_cnt));
    assign last_wr = pix_hit && (wr_cnt == cam_pkg::CNT_W'(cam_pkg::H_ACT - 1));
    assign last_rd = rd_en && (rd_ptr == cam_pkg::ADDR_W'(cam_pkg::H_ACT - 1));

    assign line_ready = (state == cam_pkg::LB_DRAIN);
    assign busy       = (state != cam_pkg::LB_IDLE);
    assign pix_data   = mem[rd_ptr];                  // read port is combinational.

    ////////////////////////////////////////////////////////////
    // capture and drain control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state    <= cam_pkg::LB_IDLE;
            wr_cnt   <= '0;
            rd_ptr   <= '0;
            line_err <= 1'b0;
        end else begin
            line_err <= col_bad;                      // one pulse per misplaced column.
            case (state)
                cam_pkg::LB_IDLE: begin
                    if (cap_trig) begin
                        state <= cam_pkg::LB_HDR;
                    end
                end
                cam_pkg::LB_HDR: begin
                    if (hdr_hit) begin
                        state  <= cam_pkg::LB_FILL;
                        wr_cnt <= '0;
                    end
                end
                cam_pkg::LB_FILL: begin
                    if (pix_hit) begin
                        wr_cnt <= wr_cnt + 1'b1;
                    end
                    if (last_wr) begin
                        state  <= cam_pkg::LB_DRAIN;
                        rd_ptr <= '0;
                    end
                end
                cam_pkg::LB_DRAIN: begin
                    if (rd_en) begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                    if (last_rd) begin
                        state <= cam_pkg::LB_IDLE;
                    end
                end
                default: begin
                    state <= cam_pkg::LB_IDLE;
                end
            endcase
        end
    end

    // pixels land at the expected column even when the word says otherwise.
    always_ff @(posedge rclk) begin
        if (pix_hit) begin
            mem[wr_cnt[cam_pkg::ADDR_W-1:0]] <= cam_pack.pix.data;
        end
    end

    always_ff @(posedge rclk) begin
        if (hdr_hit) begin
            row <= cam_pack.hdr.row;
        end
    end

    // the readout stage must never pull from a buffer that has no line.
    a_rd_only_when_ready: assert property (@(posedge rclk) disable iff (!rstn)
        rd_en |-> line_ready);

    a_wr_cnt_bound: assert property (@(posedge rclk) disable iff (!rstn)
        wr_cnt <= cam_pkg::CNT_W'(cam_pkg::H_ACT));

endmodule : line_buffer

//--- src/line_swap_top.sv
module line_swap_top (
    input  logic                                   rclk,
    input  logic                                   rstn,
    input  logic                                   trig,
    input  cam_pkg::cam_pack_t [cam_pkg::NUM_CAM-1:0] cam_pack,
    input  logic                                   read_en,
    output logic                                   acquire,
    output logic                                   error,
    output logic [cam_pkg::PIX_W-1:0]              cam_data,
    output logic [cam_pkg::ROW_W-1:0]              cam_row,
    output logic [cam_pkg::ID_W-1:0]               cam_id
);

    logic [cam_pkg::NUM_CAM-1:0]                     cap_trig;
    logic [cam_pkg::NUM_CAM-1:0]                     busy;
    logic                                            cam_sel;
    logic [cam_pkg::NUM_CAM-1:0]                     line_ready;
    logic [cam_pkg::NUM_CAM-1:0][cam_pkg::PIX_W-1:0] pix_data;
    logic [cam_pkg::NUM_CAM-1:0][cam_pkg::ROW_W-1:0] row;
    logic [cam_pkg::NUM_CAM-1:0]                     line_err;
    logic [cam_pkg::NUM_CAM-1:0]                     rd_en;

    capture_sequencer u_seq (
        .rclk     (rclk),
        .rstn     (rstn),
        .trig     (trig),
        .busy     (busy),
        .cap_trig (cap_trig),
        .cam_sel  (cam_sel)
    );

    ////////////////////////////////////////////////////////////
    // one line buffer per camera
    ////////////////////////////////////////////////////////////
    for (genvar i = 0; i < cam_pkg::NUM_CAM; i++) begin : g_cam
        line_buffer u_buf (
            .rclk       (rclk),
            .rstn       (rstn),
            .cam_pack   (cam_pack[i]),
            .cap_trig   (cap_trig[i]),
            .line_ready (line_ready[i]),
            .busy       (busy[i]),
            .rd_en      (rd_en[i]),
            .pix_data   (pix_data[i]),
            .row        (row[i]),
            .line_err   (line_err[i])
        );
    end

    readout_mux u_mux (
        .rclk       (rclk),
        .rstn       (rstn),
        .cam_sel    (cam_sel),
        .line_ready (line_ready),
        .pix_data   (pix_data),
        .row        (row),
        .line_err   (line_err),
        .read_en    (read_en),
        .rd_en      (rd_en),
        .acquire    (acquire),
        .cam_data   (cam_data),
        .cam_row    (cam_row),
        .cam_id     (cam_id),
        .error      (error)
    );

endmodule : line_swap_top

//--- src/readout_mux.sv
module readout_mux (
    input  logic                                          rclk,
    input  logic                                          rstn,
    input  logic                                          cam_sel,
    input  logic [cam_pkg::NUM_CAM-1:0]                   line_ready,
    input  logic [cam_pkg::NUM_CAM-1:0][cam_pkg::PIX_W-1:0] pix_data,
    input  logic [cam_pkg::NUM_CAM-1:0][cam_pkg::ROW_W-1:0] row,
    input  logic [cam_pkg::NUM_CAM-1:0]                   line_err,
    input  logic                                          read_en,
    output logic [cam_pkg::NUM_CAM-1:0]                   rd_en,
    output logic                                          acquire,
    output logic [cam_pkg::PIX_W-1:0]                     cam_data,
    output logic [cam_pkg::ROW_W-1:0]                     cam_row,
    output logic [cam_pkg::ID_W-1:0]                      cam_id,
    output logic                                          error
);

    logic rd_hit;

    assign acquire = line_ready[cam_sel];
    assign rd_hit  = read_en && acquire;              // reads outside acquire are dropped.

    always_comb begin
        rd_en          = '0;
        rd_en[cam_sel] = rd_hit;
    end

    always_ff @(posedge rclk) begin
        if (rd_hit) begin
            cam_data <= pix_data[cam_sel];
            cam_row  <= row[cam_sel];
            cam_id   <= cam_pkg::CAM_ID[cam_sel];
        end
    end

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            error <= 1'b0;
        end else if (|line_err) begin
            error <= 1'b1;                            // held until reset.
        end
    end

endmodule : readout_mux

//--- testbench/tb_checker.sv
module tb_checker (
    input  logic                      rclk,
    input  logic                      rstn,
    input  logic                      read_en,
    input  logic                      acquire,
    input  logic [cam_pkg::PIX_W-1:0] cam_data,
    input  logic [cam_pkg::ROW_W-1:0] cam_row,
    input  logic [cam_pkg::ID_W-1:0]  cam_id,
    input  logic                      error,
    output int                        fails
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WORD_W = cam_pkg::PIX_W + cam_pkg::ROW_W + cam_pkg::ID_W;

    logic [WORD_W-1:0] exp_q [$];                     // data, row and id of each word.
    string             test_name;
    logic              exp_err;
    int                test_fails;
    int                word_idx;
    int                tests_run;
    int                tests_failed;
    logic              rd_seen;

    initial begin
        fails        = 0;
        test_name    = "none";
        exp_err      = 1'b0;
        test_fails   = 0;
        word_idx     = 0;
        tests_run    = 0;
        tests_failed = 0;
        rd_seen      = 1'b0;
    end

    task automatic start_test(input string name, input logic err_level);
        test_name  = name;
        exp_err    = err_level;
        test_fails = 0;
        word_idx   = 0;
        exp_q.delete();
    endtask

    task automatic expect_word(input logic [cam_pkg::PIX_W-1:0] data,
                               input logic [cam_pkg::ROW_W-1:0] row,
                               input logic [cam_pkg::ID_W-1:0]  id);
        exp_q.push_back({data, row, id});
    endtask

    task automatic note_fail();
        test_fails++;
        fails++;
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s %s expected %b actual %b", test_name, what, exp, act);
            note_fail();
        end
    endtask

    task automatic compare_word();
        logic [WORD_W-1:0] exp_w;
        logic [WORD_W-1:0] act_w;
        act_w = {cam_data, cam_row, cam_id};
        if (exp_q.size() == 0) begin
            $display("%s: an output word appeared when none was expected", test_name);
            note_fail();
        end else begin
            exp_w = exp_q.pop_front();
            if (act_w !== exp_w) begin
                $display("ERR %s word %0d expected data %h row %0d id %b actual data %h row %0d id %b",
                         test_name, word_idx, exp_w[31:16], exp_w[15:5], exp_w[4:0],
                         act_w[31:16], act_w[15:5], act_w[4:0]);
                note_fail();
            end
        end
        word_idx++;
    endtask

    task automatic finish_test();
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected words never came out", test_name, exp_q.size());
            note_fail();
        end
        check_bit("error", exp_err, error);
        tests_run++;
        if (test_fails == 0) begin
            $display("pass %s", test_name);
        end else begin
            tests_failed++;
            $display("fail %s with %0d mismatches", test_name, test_fails);
        end
    endtask

    task automatic report();
        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, fails);
    endtask

    ////////////////////////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////////////////////////
    // a read honored at one rising edge shows its word by the next falling edge.
    always @(negedge rclk) begin
        if (!rstn) begin
            rd_seen = 1'b0;
        end else begin
            if (rd_seen) begin
                compare_word();
            end
            rd_seen = read_en && acquire;
        end
    end

endmodule : tb_checker

//--- testbench/tb_clock.sv
module tb_clock (
    output logic rclk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        rclk = 1'b0;
        forever #5 rclk = ~rclk;                      // 10 ns period.
    end

    initial begin
        rstn = 1'b0;
        repeat (2) @(posedge rclk);
        #1 rstn = 1'b1;                               // released with the stimulus offset.
    end

endmodule : tb_clock

//--- testbench/tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SETUP    = 8;                      // trigger reaches the buffer well within this.
    localparam int SWAP_COL = 10;

    typedef struct {
        string                     name;
        logic [cam_pkg::ROW_W-1:0] row0;
        logic [cam_pkg::ROW_W-1:0] row1;
        int                        junk;
        bit                        swap;
        int                        swap_cam;
        bit                        gaps;
        bit                        exp_err;
    } test_t;

    logic                                      rclk;
    logic                                      rstn;
    logic                                      trig;
    logic                                      read_en;
    cam_pkg::cam_pack_t [cam_pkg::NUM_CAM-1:0] cam_pack;
    logic                                      acquire;
    logic                                      error;
    logic [cam_pkg::PIX_W-1:0]                 cam_data;
    logic [cam_pkg::ROW_W-1:0]                 cam_row;
    logic [cam_pkg::ID_W-1:0]                  cam_id;
    int                                        fails;
    test_t                                     tests [$];
    logic [31:0]                               lfsr = 32'hf9ab;
    int                                        cycles = 0;
    int                                        limit = 0;

    tb_clock u_clk (
        .rclk (rclk),
        .rstn (rstn)
    );

    line_swap_top dut (
        .rclk     (rclk),
        .rstn     (rstn),
        .trig     (trig),
        .cam_pack (cam_pack),
        .read_en  (read_en),
        .acquire  (acquire),
        .error    (error),
        .cam_data (cam_data),
        .cam_row  (cam_row),
        .cam_id   (cam_id)
    );

    tb_checker u_chk (
        .rclk     (rclk),
        .rstn     (rstn),
        .read_en  (read_en),
        .acquire  (acquire),
        .cam_data (cam_data),
        .cam_row  (cam_row),
        .cam_id   (cam_id),
        .error    (error),
        .fails    (fails)
    );

    function automatic bit lfsr_bit();
        bit fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32, 22, 2, 1.
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    task automatic step();
        @(posedge rclk);
        #1;
    endtask

    task automatic send_word(input int cam, input cam_pkg::cam_pack_t w);
        cam_pack[cam] = w;
        step();
    endtask

    ////////////////////////////////////////////////////////////
    // camera stream and reader
    ////////////////////////////////////////////////////////////
    task automatic stream_line(input int cam, input int t);
        cam_pkg::cam_pack_t        w;
        logic [cam_pkg::ROW_W-1:0] row;
        logic [cam_pkg::ID_W-1:0]  id;
        int                        col;
        row = (cam == 0) ? tests[t].row0 : tests[t].row1;
        id  = 5'b10000 >> cam;                        // one-hot, camera 0 on the top bit.
        for (int j = 0; j < tests[t].junk; j++) begin
            w          = '0;
            w.pix.valid = 1'b1;
            w.pix.col  = cam_pkg::COL_W'(j);
            w.pix.data = cam_pkg::PIX_W'(rand_bits(cam_pkg::PIX_W));
            send_word(cam, w);                        // no header yet, so this is dropped.
        end
        w               = '0;
        w.hdr.valid     = 1'b1;
        w.hdr.is_header = 1'b1;
        w.hdr.row       = row;
        w.hdr.frame     = cam_pkg::FRM_W'(t);
        send_word(cam, w);
        for (int c = 0; c < cam_pkg::H_ACT; c++) begin
            col = c;
            if (tests[t].swap && tests[t].swap_cam == cam) begin
                if (c == SWAP_COL) begin
                    col = c + 1;
                end else if (c == SWAP_COL + 1) begin
                    col = c - 1;
                end
            end
            w           = '0;
            w.pix.valid = 1'b1;
            w.pix.col   = cam_pkg::COL_W'(col);
            w.pix.data  = cam_pkg::PIX_W'(rand_bits(cam_pkg::PIX_W));
            u_chk.expect_word(w.pix.data, row, id);   // stored in arrival order.
            send_word(cam, w);
        end
        cam_pack[cam] = '0;
    endtask

    task automatic read_line(input bit gaps);
        int gap;
        for (int n = 0; n < cam_pkg::H_ACT; n++) begin
            if (gaps) begin
                gap = rand_bits(2);
                repeat (gap) step();
            end
            while (!acquire) step();
            read_en = 1'b1;
            step();
            read_en = 1'b0;
        end
    endtask

    task automatic run_test(input int t);
        cam_pkg::cam_pack_t early;
        early               = '0;
        early.hdr.valid     = 1'b1;
        early.hdr.is_header = 1'b1;
        early.hdr.row       = ~tests[t].row1;         // a row camera 1 must never report.
        u_chk.start_test(tests[t].name, tests[t].exp_err);
        trig = 1'b1;
        step();
        trig = 1'b0;
        for (int cam = 0; cam < cam_pkg::NUM_CAM; cam++) begin
            repeat (SETUP) step();
            stream_line(cam, t);
            if (cam == 0) begin
                cam_pack[1] = early;                  // buffer 1 is still idle and drops it.
            end
            read_line(tests[t].gaps);
            cam_pack[1] = '0;
            u_chk.check_bit("acquire after drain", 1'b0, acquire);
        end
        repeat (4) step();
        u_chk.finish_test();
    endtask

    initial begin
        trig     = 1'b0;
        read_en  = 1'b0;
        cam_pack = '0;
        tests.push_back(test_t'{"basic",      11'd12,  11'd13,   0, 1'b0, 0, 1'b0, 1'b0});
        tests.push_back(test_t'{"junk_first", 11'd100, 11'd101,  5, 1'b0, 0, 1'b0, 1'b0});
        tests.push_back(test_t'{"read_gaps",  11'd700, 11'd2047, 2, 1'b0, 0, 1'b1, 1'b0});
        tests.push_back(test_t'{"swap_cam1",  11'd3,   11'd4,    0, 1'b1, 1, 1'b0, 1'b1});
        tests.push_back(test_t'{"after_err",  11'd55,  11'd56,   1, 1'b0, 0, 1'b1, 1'b1});
        foreach (tests[i]) begin
            limit += 2 * cam_pkg::NUM_CAM
                     * (cam_pkg::H_ACT + tests[i].junk
                        + (tests[i].gaps ? 3 * cam_pkg::H_ACT : 0) + 20);
        end
        wait (rstn);
        u_chk.start_test("reset", 1'b0);
        read_en = 1'b1;                               // nothing may come out before a trigger.
        repeat (4) step();
        read_en = 1'b0;
        u_chk.check_bit("acquire", 1'b0, acquire);
        repeat (2) step();
        u_chk.finish_test();
        foreach (tests[i]) begin
            run_test(i);
        end
        u_chk.report();
        if (fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    always @(posedge rclk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: the run went past its limit of %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule : tb_top
